// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

  typedef logic [4:0] reg_addr_t; // Register index

  // Major opcodes, prefixed opc_ so they stay apart from op_e names
  typedef enum logic [6:0] {
    opc_reg    = 7'b0110011,
    opc_imm    = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_t;

  // Operations understood by execute, nop first so a cleared slot is a nop
  typedef enum logic [3:0] {
    op_nop,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_lui,
    op_beq,
    op_bne,
    op_blt,
    op_jal
  } op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } instr_r_t;

  // B layout, J immediate is also picked out of these fields
  typedef struct packed {
    logic       imm_12;   // Bit 31, also J imm[20]
    logic [5:0] imm_10_5; // Bits 30:25
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;  // Bits 11:8
    logic       imm_11;   // Bit 7
    logic [6:0] opcode;
  } instr_b_t;

  typedef union packed {
    instr_r_t r; // R/I/U view
    instr_b_t b; // B/J view
  } instr_u;

  localparam logic [31:0] nop_word = 32'h0000_0013; // addi x0,x0,0

endpackage

`default_nettype wire

// ==== src/issue_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// One decoded instruction sitting in the ID/EX register
interface issue_if #(
  parameter int xlen = 64
) ();

  logic                valid; // ID/EX holds a real instruction
  core_pkg::op_e       op;
  logic [xlen-1:0]     rs1_val;
  logic [xlen-1:0]     rs2_val;
  logic [xlen-1:0]     imm;
  core_pkg::reg_addr_t rd;    // Zero for non-writing ops
  logic [xlen-1:0]     pc;

  modport source (output valid, op, rs1_val, rs2_val, imm, rd, pc);
  modport sink (input valid, op, rs1_val, rs2_val, imm, rd, pc);

endinterface

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
  parameter int xlen = 64
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [xlen-1:0]  entry,
  input  logic [31:0]      imem_data,
  input  logic             stall,
  input  logic             redirect,
  input  logic [xlen-1:0]  redirect_pc,
  output logic [xlen-1:0]  imem_addr,
  output logic             fetch_valid,
  output core_pkg::instr_u fetch_instr,
  output logic [xlen-1:0]  fetch_pc
);

  logic [xlen-1:0] pc;

  assign imem_addr = pc; // Word comes back in the same cycle

  // PC and IF/ID control
  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= entry; // Start address
      fetch_valid <= 1'b0;
      fetch_instr <= core_pkg::nop_word;
    end else if (redirect) begin
      pc          <= redirect_pc; // Taken jump wins over stall
      fetch_valid <= 1'b0;
      fetch_instr <= core_pkg::nop_word; // Squash word in flight
    end else if (!stall) begin
      pc          <= pc + xlen'(4);
      fetch_valid <= 1'b1;
      fetch_instr <= imem_data;
    end
  end

  // PC of the IF/ID word
  always_ff @(posedge clk) begin
    if (!stall) begin
      fetch_pc <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== src/decode_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_unit #(
  parameter int xlen = 64
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                fetch_valid,
  input  core_pkg::instr_u    fetch_instr,
  input  logic [xlen-1:0]     fetch_pc,
  input  logic                redirect,
  input  logic [xlen-1:0]     rd_data1,
  input  logic [xlen-1:0]     rd_data2,
  output core_pkg::reg_addr_t rd_addr1,
  output core_pkg::reg_addr_t rd_addr2,
  output logic                stall,
  issue_if.source             issue
);

  core_pkg::instr_u    instr;
  core_pkg::op_e       op_next;
  core_pkg::reg_addr_t rd_next;
  logic [xlen-1:0]     imm_next;
  logic                use_rs1;
  logic                use_rs2;
  logic                hazard1;
  logic                hazard2;

  // Empty slot decodes as a nop, so it reads x0 and never stalls
  assign instr = fetch_valid ? fetch_instr : core_pkg::nop_word;

  always_comb begin
    op_next  = core_pkg::op_nop;
    rd_next  = instr.r.rd;
    imm_next = '0; // Register forms keep a zero imm
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    case (core_pkg::opcode_t'(instr.r.opcode))
      core_pkg::opc_reg: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({instr.r.funct7, instr.r.funct3})
          {7'b0000000, 3'b000}: op_next = core_pkg::op_add;
          {7'b0100000, 3'b000}: op_next = core_pkg::op_sub;
          {7'b0000000, 3'b111}: op_next = core_pkg::op_and;
          {7'b0000000, 3'b110}: op_next = core_pkg::op_or;
          {7'b0000000, 3'b100}: op_next = core_pkg::op_xor;
          {7'b0000000, 3'b010}: op_next = core_pkg::op_slt;
          default: op_next = core_pkg::op_nop;
        endcase
      end
      core_pkg::opc_imm: begin
        use_rs1  = 1'b1; // rs2 stays x0, so rs2_val reads zero
        imm_next = $signed({instr.r.funct7, instr.r.rs2}); // I imm
        case (instr.r.funct3)
          3'b000:  op_next = core_pkg::op_add;
          3'b111:  op_next = core_pkg::op_and;
          3'b110:  op_next = core_pkg::op_or;
          3'b100:  op_next = core_pkg::op_xor;
          3'b010:  op_next = core_pkg::op_slt;
          default: op_next = core_pkg::op_nop;
        endcase
      end
      core_pkg::opc_lui: begin
        op_next  = core_pkg::op_lui;
        imm_next = $signed({instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0});
      end
      core_pkg::opc_branch: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        rd_next  = '0; // Branches write nothing
        imm_next = $signed({instr.b.imm_12, instr.b.imm_11, instr.b.imm_10_5,
                            instr.b.imm_4_1, 1'b0});
        case (instr.b.funct3)
          3'b000:  op_next = core_pkg::op_beq;
          3'b001:  op_next = core_pkg::op_bne;
          3'b100:  op_next = core_pkg::op_blt;
          default: op_next = core_pkg::op_nop;
        endcase
      end
      core_pkg::opc_jal: begin
        op_next  = core_pkg::op_jal;
        // imm[20|19:12|11|10:5|4:1] scattered over the B fields
        imm_next = $signed({instr.b.imm_12, instr.b.rs1, instr.b.funct3, instr.b.rs2[0],
                            instr.b.imm_10_5, instr.b.rs2[4:1], 1'b0});
      end
      default: op_next = core_pkg::op_nop;
    endcase
    if (op_next == core_pkg::op_nop) begin
      rd_next = '0; // Unknown encoding, no write and no reads
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
    end
  end

  assign rd_addr1 = use_rs1 ? instr.r.rs1 : '0;
  assign rd_addr2 = use_rs2 ? instr.r.rs2 : '0;

  // Producer still in ID/EX, commit-stage producers are bypassed by the register file
  assign hazard1 = (rd_addr1 != '0) && (rd_addr1 == issue.rd);
  assign hazard2 = (rd_addr2 != '0) && (rd_addr2 == issue.rd);
  assign stall   = issue.valid && (hazard1 || hazard2);

  always_ff @(posedge clk) begin
    if (reset) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= fetch_valid && !stall && !redirect; // Bubble on stall or flush
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    issue.op      <= op_next;
    issue.rd      <= rd_next;
    issue.rs1_val <= rd_data1;
    issue.rs2_val <= rd_data2;
    issue.imm     <= imm_next;
    issue.pc      <= fetch_pc;
  end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file #(
  parameter int xlen = 64
) (
  input  logic                clk,
  input  logic                reset,
  input  core_pkg::reg_addr_t rd_addr1,
  input  core_pkg::reg_addr_t rd_addr2,
  input  logic                wr_en,
  input  core_pkg::reg_addr_t wr_addr,
  input  logic [xlen-1:0]     wr_data,
  output logic [xlen-1:0]     rd_data1,
  output logic [xlen-1:0]     rd_data2
);

  logic [xlen-1:0] regs [1:31]; // No storage for x0

  // x0 reads zero, a same-cycle write is seen by the read
  function automatic logic [xlen-1:0] read_port(input core_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en && (wr_addr == addr)) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    rd_data1 = read_port(rd_addr1);
    rd_data2 = read_port(rd_addr2);
  end

endmodule

`default_nettype wire

// ==== src/alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_unit #(
  parameter int xlen = 64
) (
  issue_if.sink           issue,
  output logic [xlen-1:0] alu_result
);

  logic [xlen-1:0] operand_b;
  logic            less;

  // Immediate forms read x0 for rs2, register forms carry imm zero,
  // so only one side is ever nonzero
  assign operand_b = issue.rs2_val | issue.imm;

  assign less = $signed(issue.rs1_val) < $signed(operand_b); // Signed compare

  always_comb begin
    case (issue.op)
      core_pkg::op_add: alu_result = issue.rs1_val + operand_b;
      core_pkg::op_sub: alu_result = issue.rs1_val - operand_b;
      core_pkg::op_and: alu_result = issue.rs1_val & operand_b;
      core_pkg::op_or:  alu_result = issue.rs1_val | operand_b;
      core_pkg::op_xor: alu_result = issue.rs1_val ^ operand_b;
      core_pkg::op_slt: alu_result = {{(xlen-1){1'b0}}, less};
      core_pkg::op_lui: alu_result = issue.imm; // Already shifted by decode
      default:          alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_unit #(
  parameter int xlen = 64
) (
  issue_if.sink           issue,
  output logic            taken,
  output logic [xlen-1:0] target,
  output logic [xlen-1:0] link
);

  logic cond;

  assign target = issue.pc + issue.imm; // B or J offset
  assign link   = issue.pc + xlen'(4);  // Return address for jal

  always_comb begin
    case (issue.op)
      core_pkg::op_beq: cond = issue.rs1_val == issue.rs2_val;
      core_pkg::op_bne: cond = issue.rs1_val != issue.rs2_val;
      core_pkg::op_blt: cond = $signed(issue.rs1_val) < $signed(issue.rs2_val);
      core_pkg::op_jal: cond = 1'b1;
      default:          cond = 1'b0; // Value ops never redirect
    endcase
  end

  // Bubbles never branch
  assign taken = issue.valid && cond;

endmodule

`default_nettype wire

// ==== src/commit_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_unit #(
  parameter int xlen = 64
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [xlen-1:0]     alu_result,
  input  logic                taken,
  input  logic [xlen-1:0]     target,
  input  logic [xlen-1:0]     link,
  issue_if.sink               issue,
  output logic                wr_en,
  output core_pkg::reg_addr_t wr_addr,
  output logic [xlen-1:0]     wr_data,
  output logic                redirect,
  output logic [xlen-1:0]     redirect_pc,
  output logic                retire_valid,
  output logic [xlen-1:0]     retire_pc,
  output core_pkg::reg_addr_t retire_rd,
  output logic [xlen-1:0]     retire_data
);

  logic                slot_valid;
  logic                slot_taken;
  logic [xlen-1:0]     slot_target;
  logic [xlen-1:0]     slot_pc;
  core_pkg::reg_addr_t slot_rd;
  logic [xlen-1:0]     slot_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_valid <= 1'b0;
      slot_taken <= 1'b0;
    end else begin
      slot_valid <= issue.valid && !redirect; // Own redirect squashes the next slot
      slot_taken <= taken && !redirect;
    end
  end

  always_ff @(posedge clk) begin
    slot_pc     <= issue.pc;
    slot_target <= target;
    case (issue.op)
      core_pkg::op_jal: begin
        slot_rd   <= issue.rd;
        slot_data <= link; // pc + 4
      end
      core_pkg::op_beq, core_pkg::op_bne, core_pkg::op_blt: begin
        slot_rd   <= '0;
        slot_data <= '0;
      end
      default: begin
        slot_rd   <= issue.rd;
        slot_data <= alu_result;
      end
    endcase
  end

  // Write, retire report and redirect all leave from the same register
  assign wr_en        = slot_valid;
  assign wr_addr      = slot_rd; // x0 dropped inside the register file
  assign wr_data      = slot_data;
  assign redirect     = slot_taken; // One cycle, the next slot is a bubble
  assign redirect_pc  = slot_target;
  assign retire_valid = slot_valid;
  assign retire_pc    = slot_pc;
  assign retire_rd    = slot_rd;
  assign retire_data  = slot_data;

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
  parameter int xlen = 64
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [xlen-1:0]     entry,
  input  logic [31:0]         imem_data,
  output logic [xlen-1:0]     imem_addr,
  output logic                retire_valid,
  output logic [xlen-1:0]     retire_pc,
  output core_pkg::reg_addr_t retire_rd,
  output logic [xlen-1:0]     retire_data
);

  logic                fetch_valid;
  core_pkg::instr_u    fetch_instr;
  logic [xlen-1:0]     fetch_pc;
  logic                stall;
  core_pkg::reg_addr_t rd_addr1;
  core_pkg::reg_addr_t rd_addr2;
  logic [xlen-1:0]     rd_data1;
  logic [xlen-1:0]     rd_data2;
  logic [xlen-1:0]     alu_result;
  logic                taken;
  logic [xlen-1:0]     target;
  logic [xlen-1:0]     link;
  logic                wr_en;
  core_pkg::reg_addr_t wr_addr;
  logic [xlen-1:0]     wr_data;
  logic                redirect;
  logic [xlen-1:0]     redirect_pc;

  issue_if #(.xlen(xlen)) issue (); // ID/EX contents

  fetch_unit #(.xlen(xlen)) u_fetch (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .imem_data   (imem_data),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_addr   (imem_addr),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .fetch_pc    (fetch_pc)
  );

  decode_unit #(.xlen(xlen)) u_decode (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .fetch_pc    (fetch_pc),
    .redirect    (redirect),
    .rd_data1    (rd_data1),
    .rd_data2    (rd_data2),
    .rd_addr1    (rd_addr1),
    .rd_addr2    (rd_addr2),
    .stall       (stall),
    .issue       (issue.source)
  );

  register_file #(.xlen(xlen)) u_regs (
    .clk      (clk),
    .reset    (reset),
    .rd_addr1 (rd_addr1),
    .rd_addr2 (rd_addr2),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2)
  );

  // Execute, both halves side by side
  alu_unit #(.xlen(xlen)) u_alu (
    .issue      (issue.sink),
    .alu_result (alu_result)
  );

  branch_unit #(.xlen(xlen)) u_branch (
    .issue  (issue.sink),
    .taken  (taken),
    .target (target),
    .link   (link)
  );

  commit_unit #(.xlen(xlen)) u_commit (
    .clk          (clk),
    .reset        (reset),
    .alu_result   (alu_result),
    .taken        (taken),
    .target       (target),
    .link         (link),
    .issue        (issue.sink),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

// ==== verif/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
  parameter int half_period  = 5, // ns, gives a 10 ns clock
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Reset drops 1 ns after the last reset edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

  localparam int              xlen        = 64;
  localparam int              mem_words   = 256;   // Program space from address 0
  localparam logic [xlen-1:0] entry_addr  = 'h100;
  localparam logic [31:0]     random_seed = 32'h16fc6c15;

  logic                clk;
  logic                reset;
  logic [xlen-1:0]     entry;
  logic [31:0]         imem_data;
  logic [xlen-1:0]     imem_addr;
  logic                retire_valid;
  logic [xlen-1:0]     retire_pc;
  core_pkg::reg_addr_t retire_rd;
  logic [xlen-1:0]     retire_data;

  logic [31:0]         mem [0:mem_words-1];
  int                  exp_test [$]; // Expected retirements, in program order
  logic [xlen-1:0]     exp_pc [$];
  core_pkg::reg_addr_t exp_rd [$];
  logic [xlen-1:0]     exp_data [$];

  int errors;
  int tests_passed;
  int tests_failed;
  int test_errors_at_start; // Error count when the running test began
  int idx;
  int cycles;
  int cycle_limit;
  bit timed_out;

  clock_gen #(.half_period(5), .reset_cycles(4)) u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  rv_core #(.xlen(xlen)) u_rv_core (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .imem_data    (imem_data),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  function automatic logic [31:0] read_word(input logic [xlen-1:0] addr);
    if (addr >= mem_words * 4) begin
      return core_pkg::nop_word; // Outside the modeled window
    end
    return mem[addr >> 2];
  endfunction

  // Instruction memory, the word follows the new PC 1 ns after the edge
  always @(posedge clk) begin
    #1;
    imem_data = read_word(imem_addr);
  end

  // Unused words hold add x0 with rs fields scrambled by address
  task automatic fill_memory();
    int          seed;
    logic [31:0] rnd;
    seed = random_seed;
    rnd  = $urandom(seed); // Only seeding of the run
    for (int i = 0; i < mem_words; i++) begin
      rnd    = $urandom() ^ i;
      mem[i] = {7'b0000000, rnd[9:0], 3'b000, 5'b00000, 7'b0110011};
    end
  endtask

  // Two fields make a program word, four an expected retirement
  task automatic load_golden();
    int                fd;
    int                n;
    logic [8*120-1:0]  line;
    logic [63:0]       f0;
    logic [63:0]       f1;
    logic [63:0]       f2;
    logic [63:0]       f3;
    fd = $fopen("verif/core_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file verif/core_golden.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = '0;
      n    = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%h %h %h %h", f0, f1, f2, f3);
        if (n == 2 && f0 < mem_words * 4) begin
          mem[f0 >> 2] = f1[31:0];
        end else if (n == 2) begin
          $display("Program address %h lies outside the instruction memory", f0);
          errors++;
        end else if (n == 4) begin
          exp_test.push_back(int'(f0));
          exp_pc.push_back(f1);
          exp_rd.push_back(f2[4:0]);
          exp_data.push_back(f3);
        end
      end
    end
    $fclose(fd);
    if (exp_test.size() == 0) begin
      $display("The golden file lists no expected retirements");
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected %b, actual %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_pc(input string name, input logic [xlen-1:0] expected,
                          input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_rd(input string name, input core_pkg::reg_addr_t expected,
                          input core_pkg::reg_addr_t actual);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected x%0d, actual x%0d", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  function automatic string test_name(input int num);
    case (num)
      1:       return "reset";
      2:       return "register-register ops";
      3:       return "immediates";
      4:       return "back-to-back dependencies";
      5:       return "taken control flow";
      6:       return "not-taken branches";
      default: return "unnamed";
    endcase
  endfunction

  task automatic finish_test(input int num, input bit completed);
    if (completed && errors == test_errors_at_start) begin
      tests_passed++;
      $display("Test %0d (%s) passed", num, test_name(num));
    end else begin
      tests_failed++;
      $display("Test %0d (%s) failed", num, test_name(num));
    end
    test_errors_at_start = errors;
  endtask

  initial begin
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    entry        = entry_addr; // Stable long before reset falls
    imem_data    = core_pkg::nop_word;
    fill_memory();
    load_golden();
    cycle_limit          = 4 * exp_test.size() + 20;
    test_errors_at_start = errors;

    // Nothing retires while reset is held
    @(negedge clk);
    while (reset === 1'b1) begin
      check_flag("retire_valid", 1'b0, retire_valid);
      @(negedge clk);
    end
    check_pc("imem_addr", entry_addr, imem_addr); // First fetch comes from entry
    finish_test(1, 1'b1);

    // Compare every retirement in order, sampled mid-cycle
    idx    = 0;
    cycles = 0;
    while (idx < exp_test.size() && cycles < cycle_limit) begin
      if (retire_valid === 1'b1) begin
        check_pc("retire_pc", exp_pc[idx], retire_pc);
        check_rd("retire_rd", exp_rd[idx], retire_rd);
        check_data("retire_data", exp_data[idx], retire_data);
        idx++;
        if (idx == exp_test.size() || exp_test[idx] != exp_test[idx-1]) begin
          finish_test(exp_test[idx-1], 1'b1); // Last retirement of this test
        end
      end
      @(negedge clk);
      cycles++;
    end

    if (idx < exp_test.size()) begin
      timed_out = 1'b1;
      $display("Timeout after %0d cycles, %0d retirements still missing",
               cycles, exp_test.size() - idx);
      for (int i = idx; i < exp_test.size(); i++) begin
        if (i == idx || exp_test[i] != exp_test[i-1]) begin
          finish_test(exp_test[i], 1'b0);
        end
      end
    end

    $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/core_golden.txt ====
// Program lines: <byte address> <instruction word>
// Expected lines: <test> <pc> <rd> <data>, in retirement order; all fields hex
100 00700093 // addi x1, x0, 7
104 ffd00113 // addi x2, x0, -3
108 002081b3 // add  x3, x1, x2
10c 40208233 // sub  x4, x1, x2
110 0020f2b3 // and  x5, x1, x2
114 0020e333 // or   x6, x1, x2
118 0020c3b3 // xor  x7, x1, x2
11c 00112433 // slt  x8, x2, x1
120 0020a4b3 // slt  x9, x1, x2
124 00108033 // add  x0, x1, x1
128 00100533 // add  x10, x0, x1
12c ff808593 // addi x11, x1, -8
130 ff017613 // andi x12, x2, -16
134 f000e693 // ori  x13, x1, -256
138 fff0c713 // xori x14, x1, -1
13c ffe12793 // slti x15, x2, -2
140 80000837 // lui  x16, 0x80000
144 00500913 // addi x18, x0, 5
148 012909b3 // add  x19, x18, x18
14c 40198a33 // sub  x20, x19, x1
150 013a4ab3 // xor  x21, x20, x19
154 00a08863 // beq  x1, x10, +16
158 fff00f93 // addi x31, x0, -1, squashed
15c fff00f93 // addi x31, x0, -1, squashed
160 fff00f93 // addi x31, x0, -1, squashed
164 00114863 // blt  x2, x1, +16
168 fff00f93 // addi x31, x0, -1, squashed
16c fff00f93 // addi x31, x0, -1, squashed
170 fff00f93 // addi x31, x0, -1, squashed
174 01000bef // jal  x23, +16
178 fff00f93 // addi x31, x0, -1, squashed
17c fff00f93 // addi x31, x0, -1, squashed
180 fff00f93 // addi x31, x0, -1, squashed
184 000b8c33 // add  x24, x23, x0
188 00a09863 // bne  x1, x10, +16, not taken
18c 0020c863 // blt  x1, x2, +16, not taken
190 12300c93 // addi x25, x0, 0x123
194 0000006f // jal  x0, 0, parks the core
// Register-register ops, x0 write retires but reads back zero
2 100 01 0000000000000007
2 104 02 fffffffffffffffd
2 108 03 0000000000000004
2 10c 04 000000000000000a
2 110 05 0000000000000005
2 114 06 ffffffffffffffff
2 118 07 fffffffffffffffa
2 11c 08 0000000000000001
2 120 09 0000000000000000
2 124 00 000000000000000e
2 128 0a 0000000000000007
// Immediates, sign extended
3 12c 0b ffffffffffffffff
3 130 0c fffffffffffffff0
3 134 0d ffffffffffffff07
3 138 0e fffffffffffffff8
3 13c 0f 0000000000000001
3 140 10 ffffffff80000000
// Dependency chain
4 144 12 0000000000000005
4 148 13 000000000000000a
4 14c 14 0000000000000003
4 150 15 0000000000000009
// Taken beq, blt and jal, link read back through x23
5 154 00 0000000000000000
5 164 00 0000000000000000
5 174 17 0000000000000178
5 184 18 0000000000000178
// Not-taken bne and blt fall through
6 188 00 0000000000000000
6 18c 00 0000000000000000
6 190 19 0000000000000123

// ==== project.f ====
src/core_pkg.sv
src/issue_if.sv
src/fetch_unit.sv
src/decode_unit.sv
src/register_file.sv
src/alu_unit.sv
src/branch_unit.sv
src/commit_unit.sv
src/rv_core.sv
verif/clock_gen.sv
verif/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - src/core_pkg.sv
      - src/issue_if.sv
      - src/fetch_unit.sv
      - src/decode_unit.sv
      - src/register_file.sv
      - src/alu_unit.sv
      - src/branch_unit.sv
      - src/commit_unit.sv
      - src/rv_core.sv
  - target: simulation
    files:
      - verif/clock_gen.sv
      - verif/tb_rv_core.sv
